/* sq_pkg.sv */
`default_nettype none

package sq_pkg;

	// queue geometry, one slot is kept empty so at most SQ_SIZE-1 stores are live
	localparam int SQ_SIZE  = 8;
	localparam int SQ_IDX_W = 3; // log2 of SQ_SIZE

	// word widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 64;

	typedef logic [SQ_IDX_W-1:0] sq_idx_t; // slot index, wraps naturally

	// one store slot
	typedef struct packed {
		logic [ADDR_W-1:0] addr;       // store address
		logic              addr_ready; // address has been computed
		logic [DATA_W-1:0] data;       // store data word
		logic              data_ready; // data has been produced
	} sq_entry_t;

endpackage

`default_nettype wire

/* sq_ifs.sv */
`timescale 1ns/1ps
`default_nettype none

// next-state view of the queue, so the lookup sees this cycle's updates
interface sq_state_if import sq_pkg::*; ();
	sq_entry_t [SQ_SIZE-1:0] entries; // slot array after retire, execute, dispatch
	sq_idx_t                 head;    // oldest live slot after retire
	sq_idx_t                 tail;    // next free slot after dispatch

	modport src (output entries, output head, output tail);
	modport dst (input entries, input head, input tail);
endinterface

// one load lookup request and its result
interface sq_lookup_if import sq_pkg::*; ();
	logic              rd_en;    // load is probing the queue
	logic [ADDR_W-1:0] rd_addr;  // load address
	sq_idx_t           ld_pos;   // queue tail seen by the load at its dispatch
	logic [DATA_W-1:0] rd_data;  // forwarded word
	logic              rd_valid; // forwarded word is usable
	logic              rd_stall; // load must wait

	modport fwd (
		input  rd_en,
		input  rd_addr,
		input  ld_pos,
		output rd_data,
		output rd_valid,
		output rd_stall
	);
endinterface

// allocation status and the head store going to memory
interface sq_alloc_if import sq_pkg::*; ();
	sq_idx_t           tail;        // slot the next dispatch takes
	logic              full;
	logic              empty;
	logic [ADDR_W-1:0] commit_addr; // head slot address
	logic [DATA_W-1:0] commit_data; // head slot data

	modport src (
		output tail,
		output full,
		output empty,
		output commit_addr,
		output commit_data
	);
	modport dst (
		input tail,
		input full,
		input empty,
		input commit_addr,
		input commit_data
	);
endinterface

`default_nettype wire

/* store_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module store_queue import sq_pkg::*; (
	input  logic              clock,
	input  logic              reset,

	// dispatch, in program order
	input  logic              dispatch_en,
	input  logic [ADDR_W-1:0] dispatch_addr,
	input  logic              dispatch_addr_ready, // address known at dispatch
	input  logic [DATA_W-1:0] dispatch_data,
	input  logic              dispatch_data_ready, // data known at dispatch

	// execute fills in a late address or data by slot index
	input  logic              ex_en,
	input  sq_idx_t           ex_index,
	input  logic [ADDR_W-1:0] ex_addr,
	input  logic              ex_addr_en,
	input  logic [DATA_W-1:0] ex_data,
	input  logic              ex_data_en,

	// retire drains the head
	input  logic              rt_en,

	sq_state_if.src           state, // next state, for the same-cycle lookup
	sq_alloc_if.src           alloc  // registered status and commit port
);

	// payload storage
	logic [ADDR_W-1:0]  addr_q [SQ_SIZE];
	logic [DATA_W-1:0]  data_q [SQ_SIZE];

	// control state
	logic [SQ_SIZE-1:0] addr_rdy_q;
	logic [SQ_SIZE-1:0] data_rdy_q;
	sq_idx_t            head_q; // oldest live store
	sq_idx_t            tail_q; // next free slot

	sq_entry_t [SQ_SIZE-1:0] cur_entries; // registered slots as structs
	sq_entry_t [SQ_SIZE-1:0] nxt_entries;
	sq_idx_t                 head_n;
	sq_idx_t                 tail_n;
	sq_idx_t                 tail_inc;   // tail_n + 1 with wrap
	logic                    is_empty;

	assign is_empty = (head_q == tail_q);

	// gather the split storage into one entry per slot
	for (genvar g = 0; g < SQ_SIZE; g++) begin : g_pack
		assign cur_entries[g].addr       = addr_q[g];
		assign cur_entries[g].addr_ready = addr_rdy_q[g];
		assign cur_entries[g].data       = data_q[g];
		assign cur_entries[g].data_ready = data_rdy_q[g];
	end

	// next state, order is retire then execute then dispatch
	always_comb begin
		nxt_entries = cur_entries;
		head_n      = head_q;
		tail_n      = tail_q;

		// retire frees the head slot, ignored on an empty queue
		if (rt_en && !is_empty) begin
			nxt_entries[head_n].addr_ready = 1'b0;
			nxt_entries[head_n].data_ready = 1'b0;
			head_n = head_n + 1'b1;
		end

		// execute writes by index
		if (ex_en) begin
			if (ex_addr_en) begin
				nxt_entries[ex_index].addr       = ex_addr;
				nxt_entries[ex_index].addr_ready = 1'b1;
			end
			if (ex_data_en) begin
				nxt_entries[ex_index].data       = ex_data;
				nxt_entries[ex_index].data_ready = 1'b1;
			end
		end

		// dispatch takes the tail slot unless it would hit the post-retire head
		tail_inc = tail_n + 1'b1;
		if (dispatch_en && (tail_inc != head_n)) begin
			nxt_entries[tail_n].addr       = dispatch_addr;
			nxt_entries[tail_n].addr_ready = dispatch_addr_ready;
			nxt_entries[tail_n].data       = dispatch_data;
			nxt_entries[tail_n].data_ready = dispatch_data_ready;
			tail_n = tail_inc; // full dispatch is silently dropped
		end
	end

	// pointers and ready flags
	always_ff @(posedge clock) begin
		if (reset) begin
			head_q     <= '0;
			tail_q     <= '0;
			addr_rdy_q <= '0;
			data_rdy_q <= '0;
		end else begin
			head_q <= head_n;
			tail_q <= tail_n;
			for (int i = 0; i < SQ_SIZE; i++) begin
				addr_rdy_q[i] <= nxt_entries[i].addr_ready;
				data_rdy_q[i] <= nxt_entries[i].data_ready;
			end
		end
	end

	// address and data words
	always_ff @(posedge clock) begin
		for (int i = 0; i < SQ_SIZE; i++) begin
			addr_q[i] <= nxt_entries[i].addr;
			data_q[i] <= nxt_entries[i].data;
		end
	end

	// bypass view for the forwarding block
	assign state.entries = nxt_entries;
	assign state.head    = head_n;
	assign state.tail    = tail_n;

	// status from the registered pointers
	assign alloc.tail        = tail_q;
	assign alloc.full        = (sq_idx_t'(tail_q + 1'b1) == head_q);
	assign alloc.empty       = is_empty;
	assign alloc.commit_addr = addr_q[head_q]; // only meaningful when not empty
	assign alloc.commit_data = data_q[head_q];

endmodule

`default_nettype wire

/* load_forward.sv */
`timescale 1ns/1ps
`default_nettype none

module load_forward import sq_pkg::*; (
	sq_state_if.dst  state,  // post-update queue state
	sq_lookup_if.fwd lookup  // load probe and its result
);

	logic [SQ_SIZE-1:0] older_mask;   // live slot in [head, ld_pos) circularly
	logic [SQ_SIZE-1:0] match_mask;   // older store, known address, same word
	logic [SQ_SIZE-1:0] unknown_mask; // older store whose address is not known yet

	logic    hit;     // some older store matches
	sq_idx_t sel_idx; // youngest matching older store
	logic    sel_ready;
	logic    any_unknown;

	// per-slot masks, both ranges may wrap
	always_comb begin
		sq_idx_t slot;
		logic    in_live;
		logic    in_older;

		for (int i = 0; i < SQ_SIZE; i++) begin
			slot = sq_idx_t'(i);

			if (state.head <= state.tail) begin
				in_live = (slot >= state.head) && (slot < state.tail);
			end else begin
				in_live = (slot >= state.head) || (slot < state.tail); // wrapped
			end

			if (state.head <= lookup.ld_pos) begin
				in_older = (slot >= state.head) && (slot < lookup.ld_pos);
			end else begin
				in_older = (slot >= state.head) || (slot < lookup.ld_pos);
			end

			older_mask[i]   = in_live && in_older;
			match_mask[i]   = older_mask[i] && state.entries[i].addr_ready
				&& (state.entries[i].addr == lookup.rd_addr);
			unknown_mask[i] = older_mask[i] && !state.entries[i].addr_ready;
		end
	end

	// walk back from ld_pos-1 toward head, first match is the youngest
	always_comb begin
		sq_idx_t idx;

		hit     = 1'b0;
		sel_idx = '0;
		for (int k = 1; k <= SQ_SIZE; k++) begin
			idx = lookup.ld_pos - sq_idx_t'(k);
			if (!hit && match_mask[idx]) begin
				hit     = 1'b1;
				sel_idx = idx;
			end
		end
	end

	assign sel_ready   = state.entries[sel_idx].data_ready;
	assign any_unknown = |unknown_mask;

	// stall wins over forwarding, both low without a probe
	assign lookup.rd_stall = lookup.rd_en && (any_unknown || (hit && !sel_ready));
	assign lookup.rd_valid = lookup.rd_en && hit && sel_ready && !any_unknown;
	assign lookup.rd_data  = lookup.rd_valid ? state.entries[sel_idx].data : '0;

endmodule

`default_nettype wire

/* sq_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sq_top import sq_pkg::*; (
	input  logic              clock,
	input  logic              reset,

	// dispatch
	input  logic              dispatch_en,
	input  logic [ADDR_W-1:0] dispatch_addr,
	input  logic              dispatch_addr_ready,
	input  logic [DATA_W-1:0] dispatch_data,
	input  logic              dispatch_data_ready,

	// execute
	input  logic              ex_en,
	input  sq_idx_t           ex_index,
	input  logic [ADDR_W-1:0] ex_addr,
	input  logic              ex_addr_en,
	input  logic [DATA_W-1:0] ex_data,
	input  logic              ex_data_en,

	// retire
	input  logic              rt_en,

	// load lookup
	input  logic              rd_en,
	input  logic [ADDR_W-1:0] rd_addr,
	input  sq_idx_t           ld_pos,

	output logic [DATA_W-1:0] rd_data,
	output logic              rd_valid,
	output logic              rd_stall,

	// commit port and status
	output logic [ADDR_W-1:0] commit_addr,
	output logic [DATA_W-1:0] commit_data,
	output sq_idx_t           tail,
	output logic              full,
	output logic              empty
);

	sq_state_if  state_bus ();  // storage to forwarding, next state
	sq_lookup_if lookup_bus (); // load probe
	sq_alloc_if  alloc_bus ();  // status to the outside

	store_queue u_store_queue (
		.clock               (clock),
		.reset               (reset),
		.dispatch_en         (dispatch_en),
		.dispatch_addr       (dispatch_addr),
		.dispatch_addr_ready (dispatch_addr_ready),
		.dispatch_data       (dispatch_data),
		.dispatch_data_ready (dispatch_data_ready),
		.ex_en               (ex_en),
		.ex_index            (ex_index),
		.ex_addr             (ex_addr),
		.ex_addr_en          (ex_addr_en),
		.ex_data             (ex_data),
		.ex_data_en          (ex_data_en),
		.rt_en               (rt_en),
		.state               (state_bus.src),
		.alloc               (alloc_bus.src)
	);

	load_forward u_load_forward (
		.state  (state_bus.dst),
		.lookup (lookup_bus.fwd)
	);

	// load side onto the lookup bus
	assign lookup_bus.rd_en   = rd_en;
	assign lookup_bus.rd_addr = rd_addr;
	assign lookup_bus.ld_pos  = ld_pos;

	assign rd_data  = lookup_bus.rd_data;
	assign rd_valid = lookup_bus.rd_valid;
	assign rd_stall = lookup_bus.rd_stall;

	assign commit_addr = alloc_bus.commit_addr; // head store toward memory
	assign commit_data = alloc_bus.commit_data;
	assign tail        = alloc_bus.tail;
	assign full        = alloc_bus.full;
	assign empty       = alloc_bus.empty;

endmodule

`default_nettype wire

/* sq_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module sq_checker import sq_pkg::*; (
	input  logic              clock,
	input  logic              reset,
	input  logic              dispatch_en,
	input  logic [ADDR_W-1:0] dispatch_addr,
	input  logic              dispatch_addr_ready,
	input  logic [DATA_W-1:0] dispatch_data,
	input  logic              dispatch_data_ready,
	input  logic              ex_en,
	input  sq_idx_t           ex_index,
	input  logic [ADDR_W-1:0] ex_addr,
	input  logic              ex_addr_en,
	input  logic [DATA_W-1:0] ex_data,
	input  logic              ex_data_en,
	input  logic              rt_en,
	input  logic              rd_en,
	input  logic [ADDR_W-1:0] rd_addr,
	input  sq_idx_t           ld_pos,
	input  logic [DATA_W-1:0] rd_data,
	input  logic              rd_valid,
	input  logic              rd_stall,
	input  logic [ADDR_W-1:0] commit_addr,
	input  logic [DATA_W-1:0] commit_data,
	input  sq_idx_t           tail,
	input  logic              full,
	input  logic              empty,
	input  logic [3:0]        test_id,  // test now running
	input  logic              test_end, // one-cycle pulse after the drain
	output int                tests_passed,
	output int                tests_failed,
	output int                error_total
);

	// model of the queue
	logic [ADDR_W-1:0] m_addr [SQ_SIZE];
	logic              m_ardy [SQ_SIZE];
	logic [DATA_W-1:0] m_data [SQ_SIZE];
	logic              m_drdy [SQ_SIZE];
	int                m_head = 0;
	int                m_tail = 0;

	int test_errors = 0;
	int fwd_n       = 0; // loads forwarded in this test
	int stall_n     = 0;
	int passed_n    = 0;
	int failed_n    = 0;
	int errors_n    = 0;

	assign tests_passed = passed_n;
	assign tests_failed = failed_n;
	assign error_total  = errors_n;

	function automatic string test_name(input logic [3:0] id);
		case (id)
			4'd1:    return "reset and order";
			4'd2:    return "full";
			4'd3:    return "forwarding";
			4'd4:    return "stall";
			4'd5:    return "execute fill";
			4'd6:    return "same-cycle mix";
			default: return "unnamed";
		endcase
	endfunction

	task automatic flag_error(input string msg);
		$display("error at %0t ns: %s", $time, msg);
		test_errors = test_errors + 1;
		errors_n    = errors_n + 1;
	endtask

	task automatic model_reset();
		for (int i = 0; i < SQ_SIZE; i++) begin
			m_ardy[i] = 1'b0;
			m_drdy[i] = 1'b0;
		end
		m_head = 0;
		m_tail = 0;
	endtask

	// registered outputs against the model before this cycle's inputs
	task automatic check_registered();
		int live;
		live = (m_tail - m_head + SQ_SIZE) % SQ_SIZE;
		if (tail !== sq_idx_t'(m_tail))
			flag_error($sformatf("tail is %0d, expected %0d", tail, m_tail));
		if (empty !== (live == 0))
			flag_error($sformatf("empty is %b with %0d stores live", empty, live));
		if (full !== (live == SQ_SIZE - 1))
			flag_error($sformatf("full is %b with %0d stores live", full, live));
		if (live != 0) begin // commit port only means something with a store
			if (commit_addr !== m_addr[m_head])
				flag_error($sformatf("commit_addr %h, expected %h", commit_addr, m_addr[m_head]));
			if (commit_data !== m_data[m_head])
				flag_error($sformatf("commit_data %h, expected %h", commit_data, m_data[m_head]));
		end
	endtask

	// retire, then execute, then dispatch
	task automatic step_model();
		int nxt;
		if (rt_en && m_head != m_tail) begin
			m_ardy[m_head] = 1'b0;
			m_drdy[m_head] = 1'b0;
			m_head = (m_head + 1) % SQ_SIZE;
		end
		if (ex_en && ex_addr_en) begin
			m_addr[ex_index] = ex_addr;
			m_ardy[ex_index] = 1'b1;
		end
		if (ex_en && ex_data_en) begin
			m_data[ex_index] = ex_data;
			m_drdy[ex_index] = 1'b1;
		end
		nxt = (m_tail + 1) % SQ_SIZE;
		if (dispatch_en && nxt != m_head) begin // dropped when it would fill the spare slot
			m_addr[m_tail] = dispatch_addr;
			m_ardy[m_tail] = dispatch_addr_ready;
			m_data[m_tail] = dispatch_data;
			m_drdy[m_tail] = dispatch_data_ready;
			m_tail = nxt;
		end
	endtask

	// lookup against the already stepped model
	task automatic check_lookup();
		int                live;
		int                pos;
		int                sel;
		logic              hit;
		logic              unknown;
		logic              stop;
		logic              exp_valid;
		logic              exp_stall;
		logic [DATA_W-1:0] exp_data;

		live    = (m_tail - m_head + SQ_SIZE) % SQ_SIZE;
		sel     = 0;
		hit     = 1'b0;
		unknown = 1'b0;
		stop    = 1'b0;
		// oldest first, so the last match seen is the youngest
		for (int k = 0; k < live; k++) begin
			pos = (m_head + k) % SQ_SIZE;
			if (pos == int'(ld_pos))
				stop = 1'b1; // the load and everything after it
			if (!stop && !m_ardy[pos]) begin
				unknown = 1'b1;
			end else if (!stop && m_addr[pos] == rd_addr) begin
				hit = 1'b1;
				sel = pos;
			end
		end
		exp_stall = rd_en && (unknown || (hit && !m_drdy[sel]));
		exp_valid = rd_en && hit && !exp_stall;
		exp_data  = exp_valid ? m_data[sel] : '0;
		if (exp_valid)
			fwd_n = fwd_n + 1;
		if (exp_stall)
			stall_n = stall_n + 1;

		if (rd_valid && rd_stall)
			flag_error("rd_valid and rd_stall are both high");
		if (rd_valid !== exp_valid)
			flag_error($sformatf("rd_valid %b, expected %b", rd_valid, exp_valid));
		if (rd_stall !== exp_stall)
			flag_error($sformatf("rd_stall %b, expected %b", rd_stall, exp_stall));
		if (rd_data !== exp_data)
			flag_error($sformatf("rd_data %h, expected %h", rd_data, exp_data));
	endtask

	task automatic close_test();
		if (test_errors == 0) begin
			passed_n = passed_n + 1;
			$display("test %0d %s: passed, %0d loads forwarded, %0d stalled",
				test_id, test_name(test_id), fwd_n, stall_n);
		end else begin
			failed_n = failed_n + 1;
			$display("test %0d %s: failed with %0d errors",
				test_id, test_name(test_id), test_errors);
		end
		test_errors = 0;
		fwd_n       = 0;
		stall_n     = 0;
	endtask

	// falling edge, inputs and outputs are both settled here
	always @(negedge clock) begin
		if (reset) begin
			model_reset(); // the coming edge resets the DUT
		end else begin
			check_registered();
			step_model();   // now holds what the next edge loads
			check_lookup();
		end
		if (test_end) begin
			close_test();
		end
	end

endmodule

`default_nettype wire

/* sq_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module sq_tb import sq_pkg::*; ();

	localparam int DRAIN_LIMIT = 16; // cycles allowed for the queue to empty

	logic              clock;
	logic              reset;
	logic              dispatch_en;
	logic [ADDR_W-1:0] dispatch_addr;
	logic              dispatch_addr_ready;
	logic [DATA_W-1:0] dispatch_data;
	logic              dispatch_data_ready;
	logic              ex_en;
	sq_idx_t           ex_index;
	logic [ADDR_W-1:0] ex_addr;
	logic              ex_addr_en;
	logic [DATA_W-1:0] ex_data;
	logic              ex_data_en;
	logic              rt_en;
	logic              rd_en;
	logic [ADDR_W-1:0] rd_addr;
	sq_idx_t           ld_pos;
	logic [DATA_W-1:0] rd_data;
	logic              rd_valid;
	logic              rd_stall;
	logic [ADDR_W-1:0] commit_addr;
	logic [DATA_W-1:0] commit_data;
	sq_idx_t           tail;
	logic              full;
	logic              empty;

	logic [3:0] test_id;
	logic       test_end; // tells the checker a test is over
	int         tests_passed;
	int         tests_failed;
	int         error_total;

	logic [31:0] seed = 32'hd73;
	sq_idx_t     tail_seen; // tail as a load dispatched in this cycle sees it

	sq_top DUT (.*);

	sq_checker chk (.*);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// copy tail away from the rising edge
	always @(negedge clock) tail_seen <= tail;

	function automatic logic [31:0] lcg();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic logic chance(input int pct);
		logic [31:0] roll;
		roll = (lcg() >> 8) % 32'd100; // low bits of an lcg are weak
		return (roll < 32'(pct));
	endfunction

	// small pool so loads hit stores often
	function automatic logic [ADDR_W-1:0] pick_addr();
		logic [1:0] sel;
		sel = 2'(lcg() >> 11);
		case (sel)
			2'd0:    return 32'h0000_1000;
			2'd1:    return 32'h0000_1008;
			2'd2:    return 32'h0000_2040;
			default: return 32'h8000_0ff8;
		endcase
	endfunction

	task automatic idle_inputs();
		dispatch_en         <= 1'b0;
		dispatch_addr       <= '0;
		dispatch_addr_ready <= 1'b0;
		dispatch_data       <= '0;
		dispatch_data_ready <= 1'b0;
		ex_en               <= 1'b0;
		ex_index            <= '0;
		ex_addr             <= '0;
		ex_addr_en          <= 1'b0;
		ex_data             <= '0;
		ex_data_en          <= 1'b0;
		rt_en               <= 1'b0;
		rd_en               <= 1'b0;
		rd_addr             <= '0;
		ld_pos              <= '0;
	endtask

	// one cycle of stimulus, each knob is a percentage
	task automatic random_cycle(input int p_disp, input int p_ret, input int p_ex,
			input int p_rd, input int p_rdy);
		@(posedge clock);
		dispatch_en         <= chance(p_disp);
		dispatch_addr       <= pick_addr();
		dispatch_addr_ready <= chance(p_rdy);
		dispatch_data       <= {lcg(), lcg()};
		dispatch_data_ready <= chance(p_rdy);
		ex_en               <= chance(p_ex);
		ex_index            <= sq_idx_t'(lcg() >> 13);
		ex_addr             <= pick_addr();
		ex_addr_en          <= chance(50);
		ex_data             <= {lcg(), lcg()};
		ex_data_en          <= chance(50);
		rt_en               <= chance(p_ret);
		rd_en               <= chance(p_rd);
		rd_addr             <= pick_addr();
		ld_pos              <= chance(50) ? tail_seen : sq_idx_t'(lcg() >> 17); // half see all stores
	endtask

	// retire until empty
	task automatic drain_queue();
		int   waited;
		logic done;
		waited = 0;
		done   = 1'b0;
		while (!done && waited < DRAIN_LIMIT) begin
			@(posedge clock);
			idle_inputs();
			rt_en <= 1'b1;
			@(negedge clock);
			done   = empty;
			waited = waited + 1;
		end
		if (!done) begin
			$display("queue did not drain after %0d retire cycles", DRAIN_LIMIT);
			$display("SOME TESTS FAILED");
			$finish;
		end
	endtask

	task automatic mark_test_end();
		@(posedge clock);
		idle_inputs();
		test_end <= 1'b1;
		@(posedge clock);
		test_end <= 1'b0;
	endtask

	task automatic run_test(input logic [3:0] id, input int p_disp, input int p_ret,
			input int p_ex, input int p_rd, input int p_rdy, input int cycles);
		test_id <= id;
		for (int c = 0; c < cycles; c++) begin
			random_cycle(p_disp, p_ret, p_ex, p_rd, p_rdy);
		end
		drain_queue();
		mark_test_end();
	endtask

	initial begin
		reset = 1'b1;
		idle_inputs();
		test_id  = '0;
		test_end = 1'b0;
		repeat (16) @(posedge clock);
		reset <= 1'b0;

		run_test(4'd1, 80, 50, 0, 0, 100, 60);   // order through the commit port
		run_test(4'd2, 100, 0, 0, 20, 100, 12);  // fill past full, drain clears it
		run_test(4'd3, 60, 20, 0, 90, 100, 120); // every address and word known
		run_test(4'd4, 60, 20, 0, 90, 50, 120);  // late addresses and data
		run_test(4'd5, 60, 15, 70, 90, 30, 150); // execute fills them in
		run_test(4'd6, 50, 45, 50, 60, 60, 600); // everything at once, many wraps

		@(posedge clock); // checker counts only move on the falling edge
		$display("%0d tests passed, %0d tests failed, %0d errors",
			tests_passed, tests_failed, error_total);
		if (tests_failed == 0 && error_total == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
sq_pkg.sv
sq_ifs.sv
store_queue.sv
load_forward.sv
sq_top.sv
sq_checker.sv
sq_tb.sv

/* Makefile */
# store queue simulation with verilator

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module sq_tb -f sim.f -o Vsq_tb
	./obj_dir/Vsq_tb > sim.log 2>&1; cat sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
